//--- flist.f
+incdir+source
source/adder_types_pkg.sv
source/addsub_op_pkg.sv
source/ladner_fischer_tree.sv
source/prefix_adder.sv
source/addsub_unit.sv
verification/addsub_properties.sv
verification/addsub_tb.sv

//--- Makefile
# Verilator build and run of the add/subtract unit testbench

SRCS := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vaddsub_tb: $(SRCS) flist.f
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f flist.f --top-module addsub_tb -Mdir obj_dir

run: obj_dir/Vaddsub_tb
	./obj_dir/Vaddsub_tb | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/addsub_tb.sv
// Self-checking testbench for the add/subtract unit, run as the simulation top
`timescale 1ns/1ns
`include "adder_macros.svh"

`default_nettype none

module addsub_tb;

	import adder_types_pkg::*;
	import addsub_op_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DIRECTED_ROWS = 13;
	localparam int RANDOM_ROWS = 32;
	localparam int NUM_ROWS = DIRECTED_ROWS + RANDOM_ROWS;
	localparam int TIMEOUT_CYCLES = NUM_ROWS + 20;
	localparam int MSB = `ADDER_WIDTH - 1;

	logic  clk = 1'b0;
	logic  rst;
	logic  in_valid;
	op_t   op;
	word_t a;
	word_t b;
	logic  cin;
	logic  out_valid;
	word_t sum;
	logic  carry;
	logic  overflow;
	logic  zero;

	// Stimulus and expected results, one entry per item
	op_t   tbl_op[NUM_ROWS];
	word_t tbl_a[NUM_ROWS];
	word_t tbl_b[NUM_ROWS];
	logic  tbl_cin[NUM_ROWS];
	word_t tbl_sum[NUM_ROWS];
	logic  tbl_carry[NUM_ROWS];
	logic  tbl_ovf[NUM_ROWS];
	logic  tbl_zero[NUM_ROWS];
	int    tbl_gap[NUM_ROWS];

	// Items in flight, with the cycle each was issued in
	int pending_rows[$];
	int pending_cycle[$];

	int cycle_count = 0;
	int mismatch_errors = 0;
	int other_errors = 0;
	int missing_results = 0;

	addsub_unit dut0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.op(op),
		.a(a),
		.b(b),
		.cin(cin),
		.out_valid(out_valid),
		.sum(sum),
		.carry(carry),
		.overflow(overflow),
		.zero(zero)
	);

	bind addsub_unit addsub_properties props0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.sum(sum),
		.zero(zero)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	task automatic check_word(input word_t got, input word_t expected, input string what);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			mismatch_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic expected, input string name);
		if (got !== expected) begin
			$display("mismatch at %0t ns: flag %s is %b, expected %b", $time, name, got, expected);
			mismatch_errors++;
		end
	endtask

	// Reference arithmetic in one bit more than the word
	task automatic compute_expected(input op_t op_v, input word_t a_v, input word_t b_v,
			input logic cin_v, output word_t sum_v, output logic carry_v,
			output logic ovf_v, output logic zero_v);
		word_t                 b_eff;
		logic                  c_eff;
		logic [`ADDER_WIDTH:0] full;
		longint                sa;
		longint                sb;
		longint                total;
		longint                limit;
		b_eff = (op_v == OP_SUB || op_v == OP_SBB) ? ~b_v : b_v;
		if (op_v == OP_ADD) begin
			c_eff = 1'b0;
		end else if (op_v == OP_SUB) begin
			c_eff = 1'b1;
		end else begin
			c_eff = cin_v;
		end
		full = {1'b0, a_v} + {1'b0, b_eff} + {{`ADDER_WIDTH{1'b0}}, c_eff};
		sum_v = full[MSB:0];
		carry_v = full[`ADDER_WIDTH];
		// Signed overflow when the true signed total leaves the word's range
		sa = $signed(a_v);
		sb = $signed(b_eff);
		total = sa + sb + longint'(c_eff);
		limit = longint'(1) <<< MSB;
		ovf_v = (total >= limit) || (total < -limit);
		zero_v = (full[MSB:0] == '0);
	endtask

	task automatic set_row(input int idx, input op_t op_v, input word_t a_v, input word_t b_v,
			input logic cin_v, input word_t sum_v, input logic carry_v, input logic ovf_v,
			input logic zero_v, input int gap_v);
		tbl_op[idx] = op_v;
		tbl_a[idx] = a_v;
		tbl_b[idx] = b_v;
		tbl_cin[idx] = cin_v;
		tbl_sum[idx] = sum_v;
		tbl_carry[idx] = carry_v;
		tbl_ovf[idx] = ovf_v;
		tbl_zero[idx] = zero_v;
		tbl_gap[idx] = gap_v;
	endtask

	// Hand-worked rows: carry chains, borrows, cin steps and overflow corners
	task automatic load_directed_rows();
		set_row(0, OP_ADD, 30'h0000_0005, 30'h0000_0003, 1'b1, 30'h0000_0008, 0, 0, 0, 0);
		set_row(1, OP_ADD, 30'h3FFF_FFFF, 30'h0000_0001, 1'b0, 30'h0000_0000, 1, 0, 1, 0);
		set_row(2, OP_SUB, 30'h0123_4567, 30'h0123_4567, 1'b0, 30'h0000_0000, 1, 0, 1, 0);
		set_row(3, OP_SUB, 30'h0000_0005, 30'h0000_0009, 1'b0, 30'h3FFF_FFFC, 0, 0, 0, 1);
		set_row(4, OP_ADC, 30'h0000_0100, 30'h0000_00FF, 1'b0, 30'h0000_01FF, 0, 0, 0, 0);
		set_row(5, OP_ADC, 30'h0000_0100, 30'h0000_00FF, 1'b1, 30'h0000_0200, 0, 0, 0, 0);
		set_row(6, OP_SBB, 30'h0000_1000, 30'h0000_0001, 1'b1, 30'h0000_0FFF, 1, 0, 0, 0);
		set_row(7, OP_SBB, 30'h0000_1000, 30'h0000_0001, 1'b0, 30'h0000_0FFE, 1, 0, 0, 0);
		set_row(8, OP_ADD, 30'h1FFF_FFFF, 30'h0000_0001, 1'b0, 30'h2000_0000, 0, 1, 0, 2);
		set_row(9, OP_SUB, 30'h2000_0000, 30'h0000_0001, 1'b0, 30'h1FFF_FFFF, 1, 1, 0, 0);
		set_row(10, OP_ADD, 30'h2000_0000, 30'h1FFF_FFFF, 1'b0, 30'h3FFF_FFFF, 0, 0, 0, 0);
		set_row(11, OP_ADD, 30'h3FFF_FFF0, 30'h0000_0010, 1'b0, 30'h0000_0000, 1, 0, 1, 0);
		set_row(12, OP_ADD, 30'h0000_0000, 30'h0000_0000, 1'b1, 30'h0000_0000, 0, 0, 1, 0);
	endtask

	task automatic load_random_rows();
		op_t   op_v;
		word_t a_v;
		word_t b_v;
		logic  cin_v;
		word_t sum_v;
		logic  carry_v;
		logic  ovf_v;
		logic  zero_v;
		for (int r = 0; r < RANDOM_ROWS; r++) begin
			op_v = op_t'($urandom % 4);
			a_v = word_t'($urandom);
			b_v = word_t'($urandom);
			cin_v = ($urandom % 2) != 0;
			compute_expected(op_v, a_v, b_v, cin_v, sum_v, carry_v, ovf_v, zero_v);
			// An idle cycle after every eighth item
			set_row(DIRECTED_ROWS + r, op_v, a_v, b_v, cin_v, sum_v, carry_v, ovf_v, zero_v,
				(r % 8 == 7) ? 1 : 0);
		end
	endtask

	// Result checker, outputs are stable at the falling edge
	always @(negedge clk) begin
		int row;
		int issued;
		if (out_valid === 1'b1) begin
			if (pending_rows.size() == 0) begin
				$display("Error at %0t ns: out_valid was high with no item in flight", $time);
				other_errors++;
			end else begin
				row = pending_rows.pop_front();
				issued = pending_cycle.pop_front();
				if (cycle_count - issued != `ADDSUB_LATENCY) begin
					$display("Error at %0t ns: row %0d came out %0d cycles after its strobe",
						$time, row, cycle_count - issued);
					other_errors++;
				end
				check_word(sum, tbl_sum[row], $sformatf("sum of row %0d", row));
				check_flag(carry, tbl_carry[row], $sformatf("carry of row %0d", row));
				check_flag(overflow, tbl_ovf[row], $sformatf("overflow of row %0d", row));
				check_flag(zero, tbl_zero[row], $sformatf("zero of row %0d", row));
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int wait_cycles;
		rst = 1'b1;
		in_valid = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		cin = 1'b0;
		void'($urandom(51));
		load_directed_rows();
		load_random_rows();

		repeat (4) @(negedge clk);
		rst = 1'b0;

		for (int row = 0; row < NUM_ROWS; row++) begin
			@(negedge clk);
			in_valid = 1'b1;
			op = tbl_op[row];
			a = tbl_a[row];
			b = tbl_b[row];
			cin = tbl_cin[row];
			pending_rows.push_back(row);
			pending_cycle.push_back(cycle_count);
			for (int idle = 0; idle < tbl_gap[row]; idle++) begin
				@(negedge clk);
				in_valid = 1'b0;
			end
		end
		@(negedge clk);
		in_valid = 1'b0;

		// Drain the pipeline
		wait_cycles = 0;
		while (pending_rows.size() > 0 && wait_cycles < `ADDSUB_LATENCY + 4) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (pending_rows.size() > 0) begin
			missing_results = pending_rows.size();
			$display("Error at %0t ns: %0d results never came out of the unit",
				$time, missing_results);
		end

		$display("Checks done: %0d mismatches, %0d other errors, %0d missing results",
			mismatch_errors, other_errors, missing_results);
		if (mismatch_errors + other_errors + missing_results == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/addsub_properties.sv
// Concurrent assertions on strobe timing and the zero flag, bound into the add/subtract unit
`timescale 1ns/1ns
`include "adder_macros.svh"

`default_nettype none

module addsub_properties (
	input logic                   clk,
	input logic                   rst,
	input logic                   in_valid,
	input logic                   out_valid,
	input adder_types_pkg::word_t sum,
	input logic                   zero
);

	// Output strobe is the input strobe delayed by the pipeline depth
	strobe_latency: assert property (
		@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, `ADDSUB_LATENCY)
	) else $error("out_valid does not follow in_valid by %0d cycles", `ADDSUB_LATENCY);

	// Nothing comes out right after a reset edge
	quiet_after_reset: assert property (
		@(posedge clk)
		rst |=> !out_valid
	) else $error("out_valid high in the cycle after reset");

	// Zero flag tracks the sum whenever a result is presented
	zero_flag_match: assert property (
		@(posedge clk) disable iff (rst)
		out_valid |-> (zero == (sum == '0))
	) else $error("zero flag disagrees with sum %h", sum);

endmodule

`default_nettype wire

//--- source/addsub_unit.sv
// Two-stage pipelined 30-bit add/subtract unit with flags, the top of the adder design
`timescale 1ns/1ns
`include "adder_macros.svh"

`default_nettype none

module addsub_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	input  addsub_op_pkg::op_t     op,
	input  adder_types_pkg::word_t a,
	input  adder_types_pkg::word_t b,
	input  logic                   cin,
	output logic                   out_valid,
	output adder_types_pkg::word_t sum,
	output logic                   carry,
	output logic                   overflow,
	output logic                   zero
);

	import adder_types_pkg::*;
	import addsub_op_pkg::*;

	// Sign bit position
	localparam int MSB = `ADDER_WIDTH - 1;

	// Conditioned operands ahead of stage 1
	logic  invert_b;
	logic  cin_cond;
	word_t b_cond;

	// Stage 1 state
	logic  s1_valid;
	word_t s1_a;
	word_t s1_b;
	logic  s1_cin;

	// Adder result and flags ahead of stage 2
	word_t add_sum;
	logic  add_cout;
	logic  ovf_next;
	logic  zero_next;

	// Operand conditioning by operation
	always_comb begin
		invert_b = 1'b0;
		cin_cond = 1'b0;
		unique case (op)
			OP_ADD: begin
				invert_b = 1'b0;
				cin_cond = 1'b0;
			end
			OP_SUB: begin
				// Two's complement negate of b
				invert_b = 1'b1;
				cin_cond = 1'b1;
			end
			OP_ADC: begin
				invert_b = 1'b0;
				cin_cond = cin;
			end
			OP_SBB: begin
				// cin high means no borrow
				invert_b = 1'b1;
				cin_cond = cin;
			end
		endcase
	end

	assign b_cond = invert_b ? ~b : b;

	// Stage 1 valid
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// Stage 1 data, loaded only with a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_a   <= a;
			s1_b   <= b_cond;
			s1_cin <= cin_cond;
		end
	end

	prefix_adder adder0 (
		.a(s1_a),
		.b(s1_b),
		.cin(s1_cin),
		.sum(add_sum),
		.cout(add_cout)
	);

	// Signed overflow
	// Like-signed effective operands with a sum of the other sign
	assign ovf_next = (s1_a[MSB] == s1_b[MSB]) && (add_sum[MSB] != s1_a[MSB]);

	assign zero_next = (add_sum == '0);

	// Stage 2 valid
	// out_valid trails in_valid by ADDSUB_LATENCY edges
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s1_valid;
		end
	end

	// Stage 2 result, held between items
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			sum      <= add_sum;
			carry    <= add_cout;
			overflow <= ovf_next;
			zero     <= zero_next;
		end
	end

endmodule

`default_nettype wire

//--- source/prefix_adder.sv
// Combinational prefix adder around the Ladner-Fischer tree, used by the add/subtract unit
`timescale 1ns/1ns
`include "adder_macros.svh"

`default_nettype none

module prefix_adder (
	input  adder_types_pkg::word_t a,
	input  adder_types_pkg::word_t b,
	input  logic                   cin,
	output adder_types_pkg::word_t sum,
	output logic                   cout
);

	import adder_types_pkg::*;

	gp_t    prop;
	gp_t    gen;
	carry_t carries;

	// Per-bit propagate and generate
	// The carry-in sits in slot 0 as a generate with no propagate
	assign prop = {a ^ b, 1'b0};
	assign gen  = {a & b, cin};

	// Carry tree sees the carry-in slot and all but the top operand bit
	ladner_fischer_tree #(
		.WIDTH(`ADDER_WIDTH)
	) tree0 (
		.p(prop[`ADDER_WIDTH-1:0]),
		.g(gen[`ADDER_WIDTH-1:0]),
		.c(carries)
	);

	// Sum bit i is the half-sum of bit i with the carry into it
	assign sum = prop[`ADDER_WIDTH:1] ^ carries;

	// Top bit merged with the carry into it
	assign cout = gen[`ADDER_WIDTH] | (prop[`ADDER_WIDTH] & carries[`ADDER_WIDTH-1]);

endmodule

`default_nettype wire

//--- source/ladner_fischer_tree.sv
// Ladner-Fischer parallel-prefix carry tree, instantiated by the prefix adder
`timescale 1ns/1ns
`include "adder_macros.svh"

`default_nettype none

module ladner_fischer_tree #(
	parameter int WIDTH = `ADDER_WIDTH
) (
	input  logic [WIDTH-1:0] p,
	input  logic [WIDTH-1:0] g,
	output logic [WIDTH-1:0] c
);

	// Odd positions are resolved in log2 stages, the even ones in one extra row
	localparam int STAGES = $clog2(WIDTH);

	// Group generate/propagate after each stage
	// Row 0 holds the raw per-bit inputs
	logic [STAGES:0][WIDTH-1:0] grp_g;
	logic [STAGES:0][WIDTH-1:0] grp_p;

	assign grp_g[0] = g;
	assign grp_p[0] = p;

	genvar k;
	genvar i;

	generate
		for (k = 1; k <= STAGES; k++) begin : g_stage
			for (i = 0; i < WIDTH; i++) begin : g_bit
				// Span already covered by each side of the merge
				localparam int SPAN = 2 ** (k - 1);

				// Odd positions whose bit k-1 is set take part in this stage
				if ((i % 2 == 1) && ((i / SPAN) % 2 == 1)) begin : g_cell
					// Top of the neighbouring group, just below this block
					localparam int LOW = ((i / SPAN) * SPAN) - 1;

					if (i < 2 * SPAN) begin : g_grey
						// Span now reaches bit 0, so only the generate matters
						assign grp_g[k][i] = grp_g[k-1][i] |
							(grp_p[k-1][i] & grp_g[k-1][LOW]);
						// Group propagate is never read again here
						assign grp_p[k][i] = 1'b0;
					end else begin : g_black
						// Interior group, keep the propagate for later stages
						assign grp_g[k][i] = grp_g[k-1][i] |
							(grp_p[k-1][i] & grp_g[k-1][LOW]);
						assign grp_p[k][i] = grp_p[k-1][i] & grp_p[k-1][LOW];
					end
				end else begin : g_pass
					assign grp_g[k][i] = grp_g[k-1][i];
					assign grp_p[k][i] = grp_p[k-1][i];
				end
			end
		end
	endgenerate

	// Final grey row
	// Odd positions are finished, each even one merges with the odd one below it
	generate
		for (i = 0; i < WIDTH; i++) begin : g_out
			if (i == 0) begin : g_cin
				// Carry-in slot passes straight through
				assign c[i] = grp_g[STAGES][i];
			end else if (i % 2 == 0) begin : g_even
				assign c[i] = grp_g[STAGES][i] | (grp_p[STAGES][i] & c[i-1]);
			end else begin : g_odd
				assign c[i] = grp_g[STAGES][i];
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- source/addsub_op_pkg.sv
// Operation code type and its encodings for the add/subtract unit
`default_nettype none

package addsub_op_pkg;

	localparam int OP_WIDTH = 2;

	typedef logic [OP_WIDTH-1:0] op_t;

	// Plain add, carry-in forced low
	localparam op_t OP_ADD = 2'b00;

	// Subtract as a + ~b + 1
	localparam op_t OP_SUB = 2'b01;

	// Add with the external carry-in
	localparam op_t OP_ADC = 2'b10;

	// Subtract with borrow, a + ~b + cin
	// A high cin means no borrow pending
	localparam op_t OP_SBB = 2'b11;

endpackage

`default_nettype wire

//--- source/adder_types_pkg.sv
// Vector types for operands, sums and prefix-tree signals, imported by the adder RTL
`include "adder_macros.svh"

`default_nettype none

package adder_types_pkg;

	// Operand and sum word
	typedef logic [`ADDER_WIDTH-1:0] word_t;

	// Propagate/generate vector
	// Bit 0 is the carry-in slot, bits above it follow the operand bits
	typedef logic [`ADDER_WIDTH:0] gp_t;

	// Carries out of the prefix tree
	// Bit i is the carry into operand bit i
	typedef logic [`ADDER_WIDTH-1:0] carry_t;

endpackage

`default_nettype wire

//--- source/adder_macros.svh
// Width and latency macros that the adder RTL and its testbench include
`ifndef ADDER_MACROS_SVH
`define ADDER_MACROS_SVH

`default_nettype none

// Operand and sum width in bits
`define ADDER_WIDTH 30

// Clock edges from an accepted input strobe to the matching output strobe
`define ADDSUB_LATENCY 2

`default_nettype wire

`endif
